/* design/ladder_defs.svh */
// shared sizes for the Montgomery ladder controller
// field width, slot address width, scalar length, step count
`ifndef LADDER_DEFS_SVH
`define LADDER_DEFS_SVH

// field element width, the ALU owns the prime
`define LAD_WID 16

// operand slot address, 32 slots in the store
`define LAD_AWID 5

// scalar bits, one ladder iteration per bit
`define LAD_BITS 16

// iteration counter, counts LAD_BITS-1 down to 0
`define LAD_CNTWID 5

// microprogram steps in one iteration
// 1 scalar bit fetch, 2 conditional swaps, 18 field ops
`define LAD_STEPS 21

`endif

/* design/ladder_pkg.sv */
// ladder controller types
// operand slot names, micro-operation codes, microprogram step
`include "ladder_defs.svh"

package ladder_pkg;

    // operand store slot map, slots 19..31 unused
    typedef enum logic [`LAD_AWID-1:0] {
        SLOT_X1,    // base point u-coordinate
        SLOT_X2,
        SLOT_Z2,
        SLOT_X3,
        SLOT_Z3,
        SLOT_K,     // scalar
        SLOT_A24,   // curve constant
        SLOT_A,
        SLOT_AA,
        SLOT_B,
        SLOT_BB,
        SLOT_E,
        SLOT_T,     // z2 temporary
        SLOT_C,
        SLOT_D,
        SLOT_DA,
        SLOT_CB,
        SLOT_S,     // da-cb and its square
        SLOT_SUM    // da+cb
    } slot_e;

    // low two bits are the ALU opcode
    typedef enum logic [2:0] {
        OP_ADD  = 3'b000,
        OP_SUB  = 3'b001,
        OP_MUL  = 3'b010,
        OP_SWAP = 3'b011,
        OP_KBIT = 3'b100    // handled locally, never sent to the ALU
    } op_e;

    // one microprogram step, 23 bits
    typedef struct packed {
        op_e   op;
        slot_e src_a;
        slot_e src_b;
        slot_e dst;
        slot_e dst2;    // second target of a swap
    } step_t;

endpackage

/* design/ladder_regfile.sv */
// operand store for the ladder controller
// 32 words, two operand read ports, host readback, host and result writes
`timescale 1ns/1ps
`include "ladder_defs.svh"

module ladder_regfile
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 host_we,
    input  logic [`LAD_AWID-1:0] host_addr,
    input  logic [`LAD_WID-1:0]  host_data,
    input  logic [`LAD_AWID-1:0] addr_a,
    input  logic [`LAD_AWID-1:0] addr_b,
    input  logic [`LAD_AWID-1:0] rd_addr,
    input  logic                 we1,
    input  logic [`LAD_AWID-1:0] wa1,
    input  logic [`LAD_WID-1:0]  wd1,
    input  logic                 we2,
    input  logic [`LAD_AWID-1:0] wa2,
    input  logic [`LAD_WID-1:0]  wd2,
    output logic [`LAD_WID-1:0]  opa,
    output logic [`LAD_WID-1:0]  opb,
    output logic [`LAD_WID-1:0]  rd_data
);

    logic [`LAD_WID-1:0] mem [2**`LAD_AWID];

    always_ff @(posedge clk)
    begin
        if (host_we)
            mem[host_addr] <= host_data;
        if (we1)
            mem[wa1] <= wd1;    // arithmetic result or swap a
        if (we2)
            mem[wa2] <= wd2;    // swap b
    end

    assign opa     = mem[addr_a];
    assign opb     = mem[addr_b];
    assign rd_data = mem[rd_addr];

    // host loads are held off by busy at the top level
    a_host_vs_result: assert property (@(posedge clk) disable iff (rst)
        host_we |-> !(we1 || we2));

    // swap targets come from the microprogram table
    a_dual_write: assert property (@(posedge clk) disable iff (rst)
        (we1 && we2) |-> (wa1 != wa2));

endmodule

/* design/ladder_decode.sv */
// ladder sequencer
// iteration counter, step index, 21 step microprogram table
`timescale 1ns/1ps
`include "ladder_defs.svh"

module ladder_decode
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   step_done,
    output logic                   busy,
    output logic                   done,
    output logic                   step_go,
    output ladder_pkg::step_t      step,
    output logic [`LAD_CNTWID-1:0] cnt
);

    logic [4:0] idx;        // step index inside one iteration
    logic       launch;     // first step_go of a run
    logic       last_step;

    assign last_step = (idx == 5'(`LAD_STEPS - 1));

    ////////////////////////////////////////////////////////////////////////////
    // sequencing
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy    <= 1'b0;
            done    <= 1'b0;
            step_go <= 1'b0;
            launch  <= 1'b0;
            idx     <= '0;
            cnt     <= '0;
        end
        else
        begin
            done    <= 1'b0;
            step_go <= launch;
            launch  <= start && !busy;
            if (start && !busy)
            begin
                busy <= 1'b1;
                idx  <= '0;
                cnt  <= `LAD_CNTWID'(`LAD_BITS - 1);   // top scalar bit first
            end
            else if (step_done)
            begin
                if (!last_step)
                begin
                    idx     <= idx + 5'd1;
                    step_go <= 1'b1;
                end
                else if (cnt != '0)
                begin
                    idx     <= '0;
                    cnt     <= cnt - 1'b1;
                    step_go <= 1'b1;
                end
                else
                begin
                    busy <= 1'b0;   // falls with done
                    done <= 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // microprogram, fields are op, src_a, src_b, dst, dst2
    always_comb
    begin
        case (idx)
            5'd0:  step = '{ladder_pkg::OP_KBIT, ladder_pkg::SLOT_K, ladder_pkg::SLOT_K,
                            ladder_pkg::SLOT_K, ladder_pkg::SLOT_K};
            5'd1:  step = '{ladder_pkg::OP_SWAP, ladder_pkg::SLOT_X2, ladder_pkg::SLOT_X3,
                            ladder_pkg::SLOT_X2, ladder_pkg::SLOT_X3};
            5'd2:  step = '{ladder_pkg::OP_SWAP, ladder_pkg::SLOT_Z2, ladder_pkg::SLOT_Z3,
                            ladder_pkg::SLOT_Z2, ladder_pkg::SLOT_Z3};
            5'd3:  step = '{ladder_pkg::OP_ADD, ladder_pkg::SLOT_X2, ladder_pkg::SLOT_Z2,
                            ladder_pkg::SLOT_A, ladder_pkg::SLOT_A};
            5'd4:  step = '{ladder_pkg::OP_MUL, ladder_pkg::SLOT_A, ladder_pkg::SLOT_A,
                            ladder_pkg::SLOT_AA, ladder_pkg::SLOT_AA};
            5'd5:  step = '{ladder_pkg::OP_SUB, ladder_pkg::SLOT_X2, ladder_pkg::SLOT_Z2,
                            ladder_pkg::SLOT_B, ladder_pkg::SLOT_B};
            5'd6:  step = '{ladder_pkg::OP_MUL, ladder_pkg::SLOT_B, ladder_pkg::SLOT_B,
                            ladder_pkg::SLOT_BB, ladder_pkg::SLOT_BB};
            5'd7:  step = '{ladder_pkg::OP_SUB, ladder_pkg::SLOT_AA, ladder_pkg::SLOT_BB,
                            ladder_pkg::SLOT_E, ladder_pkg::SLOT_E};
            5'd8:  step = '{ladder_pkg::OP_MUL, ladder_pkg::SLOT_AA, ladder_pkg::SLOT_BB,
                            ladder_pkg::SLOT_X2, ladder_pkg::SLOT_X2};
            5'd9:  step = '{ladder_pkg::OP_MUL, ladder_pkg::SLOT_A24, ladder_pkg::SLOT_E,
                            ladder_pkg::SLOT_T, ladder_pkg::SLOT_T};
            5'd10: step = '{ladder_pkg::OP_ADD, ladder_pkg::SLOT_AA, ladder_pkg::SLOT_T,
                            ladder_pkg::SLOT_T, ladder_pkg::SLOT_T};
            5'd11: step = '{ladder_pkg::OP_MUL, ladder_pkg::SLOT_E, ladder_pkg::SLOT_T,
                            ladder_pkg::SLOT_Z2, ladder_pkg::SLOT_Z2};
            5'd12: step = '{ladder_pkg::OP_ADD, ladder_pkg::SLOT_X3, ladder_pkg::SLOT_Z3,
                            ladder_pkg::SLOT_C, ladder_pkg::SLOT_C};
            5'd13: step = '{ladder_pkg::OP_SUB, ladder_pkg::SLOT_X3, ladder_pkg::SLOT_Z3,
                            ladder_pkg::SLOT_D, ladder_pkg::SLOT_D};
            5'd14: step = '{ladder_pkg::OP_MUL, ladder_pkg::SLOT_D, ladder_pkg::SLOT_A,
                            ladder_pkg::SLOT_DA, ladder_pkg::SLOT_DA};
            5'd15: step = '{ladder_pkg::OP_MUL, ladder_pkg::SLOT_C, ladder_pkg::SLOT_B,
                            ladder_pkg::SLOT_CB, ladder_pkg::SLOT_CB};
            5'd16: step = '{ladder_pkg::OP_ADD, ladder_pkg::SLOT_DA, ladder_pkg::SLOT_CB,
                            ladder_pkg::SLOT_SUM, ladder_pkg::SLOT_SUM};
            5'd17: step = '{ladder_pkg::OP_MUL, ladder_pkg::SLOT_SUM, ladder_pkg::SLOT_SUM,
                            ladder_pkg::SLOT_X3, ladder_pkg::SLOT_X3};
            5'd18: step = '{ladder_pkg::OP_SUB, ladder_pkg::SLOT_DA, ladder_pkg::SLOT_CB,
                            ladder_pkg::SLOT_S, ladder_pkg::SLOT_S};
            5'd19: step = '{ladder_pkg::OP_MUL, ladder_pkg::SLOT_S, ladder_pkg::SLOT_S,
                            ladder_pkg::SLOT_S, ladder_pkg::SLOT_S};
            5'd20: step = '{ladder_pkg::OP_MUL, ladder_pkg::SLOT_X1, ladder_pkg::SLOT_S,
                            ladder_pkg::SLOT_Z3, ladder_pkg::SLOT_Z3};
            default: step = '0;
        endcase
    end

    a_done_in_run: assert property (@(posedge clk) disable iff (rst)
        step_done |-> busy);

endmodule

/* design/ladder_execute.sv */
// ladder execute stage
// issues one field op at a time to the ALU and waits for its answer
// scalar fetch steps bypass the ALU
`timescale 1ns/1ps
`include "ladder_defs.svh"

module ladder_execute
(
    input  logic                clk,
    input  logic                rst,
    input  logic                step_go,
    input  ladder_pkg::step_t   step,
    input  logic                swap_flag,
    input  logic [`LAD_WID-1:0] opa,
    input  logic [`LAD_WID-1:0] opb,
    output logic                alu_req,
    output logic [1:0]          alu_op,
    output logic                alu_swap,
    output logic [`LAD_WID-1:0] alu_a,
    output logic [`LAD_WID-1:0] alu_b,
    input  logic                alu_vld,
    input  logic [`LAD_WID-1:0] alu_res,
    input  logic [`LAD_WID-1:0] alu_res_swap,
    output logic                res_vld,
    output logic [`LAD_WID-1:0] res,
    output logic [`LAD_WID-1:0] res_swap
);

    localparam logic [1:0] EX_IDLE  = 2'd0;
    localparam logic [1:0] EX_ISSUE = 2'd1;
    localparam logic [1:0] EX_WAIT  = 2'd2;

    logic [1:0] state;

    assign alu_req = (state == EX_ISSUE);   // one cycle per request

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= EX_IDLE;
            res_vld <= 1'b0;
        end
        else
        begin
            res_vld <= 1'b0;
            case (state)
                EX_IDLE:
                begin
                    if (step_go && step.op == ladder_pkg::OP_KBIT)
                        res_vld <= 1'b1;    // K goes straight to result
                    else if (step_go)
                        state <= EX_ISSUE;
                end
                EX_ISSUE:
                    state <= EX_WAIT;
                EX_WAIT:
                begin
                    if (alu_vld)
                    begin
                        res_vld <= 1'b1;
                        state   <= EX_IDLE;
                    end
                end
                default:
                    state <= EX_IDLE;
            endcase
        end
    end

    // operand and answer registers
    always_ff @(posedge clk)
    begin
        if (state == EX_IDLE && step_go)
        begin
            alu_op   <= step.op[1:0];
            alu_swap <= swap_flag;
            alu_a    <= opa;
            alu_b    <= opb;
            res      <= opa;    // scalar word for a fetch step
        end
        else if (state == EX_WAIT && alu_vld)
        begin
            res      <= alu_res;
            res_swap <= alu_res_swap;
        end
    end

    a_vld_when_waiting: assert property (@(posedge clk) disable iff (rst)
        alu_vld |-> (state == EX_WAIT));

endmodule

/* design/ladder_result.sv */
// ladder result stage
// writes ALU answers to the store, keeps the swap flag and the previous
// scalar bit
`timescale 1ns/1ps
`include "ladder_defs.svh"

module ladder_result
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   res_vld,
    input  ladder_pkg::step_t      step,
    input  logic [`LAD_CNTWID-1:0] cnt,
    input  logic                   busy,
    input  logic [`LAD_WID-1:0]    res,
    input  logic [`LAD_WID-1:0]    res_swap,
    output logic                   we1,
    output logic                   we2,
    output logic [`LAD_AWID-1:0]   wa1,
    output logic [`LAD_AWID-1:0]   wa2,
    output logic [`LAD_WID-1:0]    wd1,
    output logic [`LAD_WID-1:0]    wd2,
    output logic                   swap_flag,
    output logic                   step_done
);

    localparam int BIT_W = $clog2(`LAD_WID);

    logic is_kbit;
    logic kbit;
    logic prev_bit;     // scalar bit of the last iteration

    assign is_kbit = (step.op == ladder_pkg::OP_KBIT);
    assign kbit    = res[cnt[BIT_W-1:0]];

    ////////////////////////////////////////////////////////////////////////////
    // control
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            we1       <= 1'b0;
            we2       <= 1'b0;
            step_done <= 1'b0;
            swap_flag <= 1'b0;
            prev_bit  <= 1'b0;
        end
        else
        begin
            we1       <= res_vld && !is_kbit;
            we2       <= res_vld && step.op == ladder_pkg::OP_SWAP;
            step_done <= res_vld;
            if (!busy)
                prev_bit <= 1'b0;
            else if (res_vld && is_kbit)
            begin
                swap_flag <= prev_bit ^ kbit;   // swap only when the bit changes
                prev_bit  <= kbit;
            end
        end
    end

    // write addresses and data
    always_ff @(posedge clk)
    begin
        if (res_vld)
        begin
            wa1 <= step.dst;
            wa2 <= step.dst2;
            wd1 <= res;
            wd2 <= res_swap;
        end
    end

endmodule

/* design/ladder_top.sv */
// Montgomery ladder controller top level
// operand store, sequencer, execute stage and result stage
`timescale 1ns/1ps
`include "ladder_defs.svh"

module ladder_top
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    output logic                 busy,
    output logic                 done,
    input  logic                 ld_we,
    input  logic [`LAD_AWID-1:0] ld_addr,
    input  logic [`LAD_WID-1:0]  ld_data,
    input  logic [`LAD_AWID-1:0] rd_addr,
    output logic [`LAD_WID-1:0]  rd_data,
    output logic                 alu_req,
    output logic [1:0]           alu_op,
    output logic                 alu_swap,
    output logic [`LAD_WID-1:0]  alu_a,
    output logic [`LAD_WID-1:0]  alu_b,
    input  logic                 alu_vld,
    input  logic [`LAD_WID-1:0]  alu_res,
    input  logic [`LAD_WID-1:0]  alu_res_swap
);

    ladder_pkg::step_t      step;
    logic                   step_go;
    logic                   step_done;
    logic [`LAD_CNTWID-1:0] cnt;
    logic                   swap_flag;
    logic [`LAD_WID-1:0]    opa;
    logic [`LAD_WID-1:0]    opb;
    logic                   res_vld;
    logic [`LAD_WID-1:0]    res;
    logic [`LAD_WID-1:0]    res_swap;
    logic                   we1;
    logic                   we2;
    logic [`LAD_AWID-1:0]   wa1;
    logic [`LAD_AWID-1:0]   wa2;
    logic [`LAD_WID-1:0]    wd1;
    logic [`LAD_WID-1:0]    wd2;

    ladder_regfile u_regfile (
        .clk(clk), .rst(rst),
        .host_we(ld_we && !busy),   // loads only between runs
        .host_addr(ld_addr), .host_data(ld_data),
        .addr_a(step.src_a), .addr_b(step.src_b), .rd_addr(rd_addr),
        .we1(we1), .wa1(wa1), .wd1(wd1),
        .we2(we2), .wa2(wa2), .wd2(wd2),
        .opa(opa), .opb(opb), .rd_data(rd_data)
    );

    ladder_decode u_decode (
        .clk(clk), .rst(rst), .start(start), .step_done(step_done),
        .busy(busy), .done(done), .step_go(step_go), .step(step), .cnt(cnt)
    );

    ladder_execute u_execute (
        .clk(clk), .rst(rst), .step_go(step_go), .step(step),
        .swap_flag(swap_flag), .opa(opa), .opb(opb),
        .alu_req(alu_req), .alu_op(alu_op), .alu_swap(alu_swap),
        .alu_a(alu_a), .alu_b(alu_b),
        .alu_vld(alu_vld), .alu_res(alu_res), .alu_res_swap(alu_res_swap),
        .res_vld(res_vld), .res(res), .res_swap(res_swap)
    );

    ladder_result u_result (
        .clk(clk), .rst(rst), .res_vld(res_vld), .step(step), .cnt(cnt),
        .busy(busy), .res(res), .res_swap(res_swap),
        .we1(we1), .we2(we2), .wa1(wa1), .wa2(wa2), .wd1(wd1), .wd2(wd2),
        .swap_flag(swap_flag), .step_done(step_done)
    );

endmodule

/* sim/tb_alu_model.sv */
// testbench ALU for the ladder controller
// add, sub, mul mod 65521 and conditional swap, random answer latency
`timescale 1ns/1ps
`include "ladder_defs.svh"

module tb_alu_model
(
    input  logic                clk,
    input  logic                rst,
    input  logic                alu_req,
    input  logic [1:0]          alu_op,
    input  logic                alu_swap,
    input  logic [`LAD_WID-1:0] alu_a,
    input  logic [`LAD_WID-1:0] alu_b,
    output logic                alu_vld,
    output logic [`LAD_WID-1:0] alu_res,
    output logic [`LAD_WID-1:0] alu_res_swap
);

    localparam int unsigned PRIME = 65521;

    initial
    begin
        int unsigned         a;
        int unsigned         b;
        int unsigned         left;      // cycles until the answer
        logic                pending;
        logic [`LAD_WID-1:0] res_q;
        logic [`LAD_WID-1:0] res_swap_q;
        alu_vld      = 1'b0;
        alu_res      = '0;
        alu_res_swap = '0;
        pending      = 1'b0;
        left         = 0;
        forever
        begin
            @(negedge clk);
            alu_vld <= 1'b0;
            if (rst)
                pending = 1'b0;
            else if (pending)
            begin
                left = left - 1;
                if (left == 0)
                begin
                    alu_vld      <= 1'b1;
                    alu_res      <= res_q;
                    alu_res_swap <= res_swap_q;
                    pending = 1'b0;
                end
            end
            else if (alu_req)
            begin
                a          = 32'(alu_a) % PRIME;
                b          = 32'(alu_b) % PRIME;
                res_swap_q = '0;
                case (alu_op)
                    2'b00:   res_q = 16'((a + b) % PRIME);
                    2'b01:   res_q = 16'((a + PRIME - b) % PRIME);
                    2'b10:   res_q = 16'((a * b) % PRIME);     // both below 2**16
                    default:
                    begin
                        res_q      = alu_swap ? alu_b : alu_a;
                        res_swap_q = alu_swap ? alu_a : alu_b;
                    end
                endcase
                left    = $urandom_range(6, 1);
                pending = 1'b1;
            end
        end
    end

endmodule

/* sim/tb_ladder.sv */
// testbench for the Montgomery ladder controller
// clock, reset, host loads, reference ladder, request monitor, checks
`timescale 1ns/1ps
`include "ladder_defs.svh"

module tb_ladder;

    localparam int unsigned PRIME      = 65521;
    localparam int unsigned RUN_REQS   = 20 * `LAD_BITS;   // 2 swaps + 18 field ops
    localparam int          MAX_CYCLES = 20000;
    localparam logic [15:0] A24        = 16'(121665 % 65521);

    logic                 clk;
    logic                 rst;
    logic                 start;
    logic                 busy;
    logic                 done;
    logic                 ld_we;
    logic [`LAD_AWID-1:0] ld_addr;
    logic [`LAD_WID-1:0]  ld_data;
    logic [`LAD_AWID-1:0] rd_addr;
    logic [`LAD_WID-1:0]  rd_data;
    logic                 alu_req;
    logic [1:0]           alu_op;
    logic                 alu_swap;
    logic [`LAD_WID-1:0]  alu_a;
    logic [`LAD_WID-1:0]  alu_b;
    logic                 alu_vld;
    logic [`LAD_WID-1:0]  alu_res;
    logic [`LAD_WID-1:0]  alu_res_swap;

    int unsigned req_cnt   = 0;
    int unsigned done_cnt  = 0;
    logic        in_flight = 1'b0;

    ladder_top u_dut (
        .clk(clk), .rst(rst), .start(start), .busy(busy), .done(done),
        .ld_we(ld_we), .ld_addr(ld_addr), .ld_data(ld_data),
        .rd_addr(rd_addr), .rd_data(rd_data),
        .alu_req(alu_req), .alu_op(alu_op), .alu_swap(alu_swap),
        .alu_a(alu_a), .alu_b(alu_b),
        .alu_vld(alu_vld), .alu_res(alu_res), .alu_res_swap(alu_res_swap)
    );

    tb_alu_model u_alu (
        .clk(clk), .rst(rst), .alu_req(alu_req), .alu_op(alu_op), .alu_swap(alu_swap),
        .alu_a(alu_a), .alu_b(alu_b),
        .alu_vld(alu_vld), .alu_res(alu_res), .alu_res_swap(alu_res_swap)
    );

    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // field model and reference ladder

    function automatic int unsigned add_mod(input int unsigned a, input int unsigned b);
        return (a + b) % PRIME;
    endfunction

    function automatic int unsigned sub_mod(input int unsigned a, input int unsigned b);
        return (a + PRIME - b) % PRIME;
    endfunction

    function automatic int unsigned mul_mod(input int unsigned a, input int unsigned b);
        return (a * b) % PRIME;
    endfunction

    // returns {x2, z2, x3, z3} after the last iteration with no final swap
    function automatic logic [63:0] ladder_ref(input logic [15:0] x1_in, input logic [15:0] k);
        int unsigned x1;
        int unsigned x2;
        int unsigned z2;
        int unsigned x3;
        int unsigned z3;
        int unsigned tmp;
        int unsigned a;
        int unsigned aa;
        int unsigned b;
        int unsigned bb;
        int unsigned e;
        int unsigned t;
        int unsigned c;
        int unsigned d;
        int unsigned da;
        int unsigned cb;
        int unsigned s;
        logic        prev;
        x1   = 32'(x1_in);
        x2   = 1;
        z2   = 0;
        x3   = x1;
        z3   = 1;
        prev = 1'b0;
        for (int i = `LAD_BITS - 1; i >= 0; i--)
        begin
            if (prev ^ k[i])
            begin
                tmp = x2;
                x2  = x3;
                x3  = tmp;
                tmp = z2;
                z2  = z3;
                z3  = tmp;
            end
            prev = k[i];
            a  = add_mod(x2, z2);
            aa = mul_mod(a, a);
            b  = sub_mod(x2, z2);
            bb = mul_mod(b, b);
            e  = sub_mod(aa, bb);
            x2 = mul_mod(aa, bb);
            t  = add_mod(aa, mul_mod(32'(A24), e));
            z2 = mul_mod(e, t);
            c  = add_mod(x3, z3);
            d  = sub_mod(x3, z3);
            da = mul_mod(d, a);
            cb = mul_mod(c, b);
            x3 = mul_mod(add_mod(da, cb), add_mod(da, cb));
            s  = sub_mod(da, cb);
            z3 = mul_mod(x1, mul_mod(s, s));
        end
        return {16'(x2), 16'(z2), 16'(x3), 16'(z3)};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // reporting and host tasks

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic load_slot(input logic [`LAD_AWID-1:0] slot, input logic [`LAD_WID-1:0] val);
        @(negedge clk);
        ld_we   = 1'b1;
        ld_addr = slot;
        ld_data = val;
        @(negedge clk);
        ld_we   = 1'b0;
    endtask

    task automatic read_slot(input logic [`LAD_AWID-1:0] slot, output logic [`LAD_WID-1:0] val);
        @(negedge clk);
        rd_addr = slot;
        @(posedge clk);
        val = rd_data;
    endtask

    task automatic wait_done();
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < MAX_CYCLES && !seen; i++)
        begin
            @(negedge clk);
            seen = done;
        end
        if (!seen)
            fail_run("timeout while waiting for done");
    endtask

    task automatic reach_req_count(input int unsigned target);
        bit reached;
        reached = 1'b0;
        for (int i = 0; i < MAX_CYCLES && !reached; i++)
        begin
            @(negedge clk);
            reached = (req_cnt >= target);
        end
        if (!reached)
            fail_run("timeout while waiting for ALU requests");
    endtask

    // one full ladder run where meddle adds a start and a load while busy
    task automatic run_ladder(input logic [15:0] x1, input logic [15:0] k, input bit meddle);
        int unsigned         req_base;
        int unsigned         done_base;
        logic [63:0]         exp_state;
        logic [`LAD_WID-1:0] val;
        exp_state = ladder_ref(x1, k);
        load_slot(ladder_pkg::SLOT_X1, x1);
        load_slot(ladder_pkg::SLOT_K, k);
        load_slot(ladder_pkg::SLOT_A24, A24);
        load_slot(ladder_pkg::SLOT_X2, 16'd1);
        load_slot(ladder_pkg::SLOT_Z2, 16'd0);
        load_slot(ladder_pkg::SLOT_X3, x1);
        load_slot(ladder_pkg::SLOT_Z3, 16'd1);
        req_base  = req_cnt;
        done_base = done_cnt;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (meddle)
        begin
            reach_req_count(req_base + 40);
            @(negedge clk);
            start   = 1'b1;
            ld_we   = 1'b1;
            ld_addr = ladder_pkg::SLOT_X1;
            ld_data = ~x1;
            @(negedge clk);
            start = 1'b0;
            ld_we = 1'b0;
        end
        wait_done();
        repeat (4) @(negedge clk);
        check_value("busy", 32'(busy), 32'd0);
        check_value("alu_req count", req_cnt - req_base, RUN_REQS);
        check_value("done count", done_cnt - done_base, 32'd1);
        read_slot(ladder_pkg::SLOT_X2, val);
        check_value("x2", 32'(val), 32'(exp_state[63:48]));
        read_slot(ladder_pkg::SLOT_Z2, val);
        check_value("z2", 32'(val), 32'(exp_state[47:32]));
        read_slot(ladder_pkg::SLOT_X3, val);
        check_value("x3", 32'(val), 32'(exp_state[31:16]));
        read_slot(ladder_pkg::SLOT_Z3, val);
        check_value("z3", 32'(val), 32'(exp_state[15:0]));
        read_slot(ladder_pkg::SLOT_X1, val);
        check_value("x1", 32'(val), 32'(x1));     // load during the run must not land
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // request monitor for one ALU op in flight at a time

    always @(negedge clk)
    begin
        if (rst)
            in_flight <= 1'b0;
        else if (alu_req)
        begin
            if (in_flight)
                fail_run("ALU request issued while another one was still outstanding");
            else
            begin
                in_flight <= 1'b1;
                req_cnt   <= req_cnt + 1;
            end
        end
        else if (alu_vld)
            in_flight <= 1'b0;
        if (done)
            done_cnt <= done_cnt + 1;
    end

    initial
    begin
        logic [15:0] x1;
        logic [15:0] k;
        void'($urandom(32'h871a578c));
        clk     = 1'b0;
        rst     = 1'b1;
        start   = 1'b0;
        ld_we   = 1'b0;
        ld_addr = '0;
        ld_data = '0;
        rd_addr = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_value("busy", 32'(busy), 32'd0);
        check_value("done", 32'(done), 32'd0);
        repeat (10)
        begin
            @(negedge clk);
            check_value("alu_req", 32'(alu_req), 32'd0);   // idle until start
        end

        for (int n = 0; n < 4; n++)
        begin
            x1 = 16'($urandom_range(PRIME - 1, 0));
            k  = 16'($urandom());
            run_ladder(x1, k, 1'b0);
        end

        // scalar edges where the flag is never set or set on the first bit only
        run_ladder(16'd9, 16'h0000, 1'b0);
        run_ladder(16'd9, 16'hffff, 1'b0);

        // alternating bits swap on every iteration
        run_ladder(16'd9, 16'haaaa, 1'b0);

        x1 = 16'($urandom_range(PRIME - 1, 0));
        k  = 16'($urandom());
        run_ladder(x1, k, 1'b1);

        $display("No errors");
        $finish;
    end

endmodule

/* compile.f */
+incdir+design
design/ladder_pkg.sv
design/ladder_regfile.sv
design/ladder_decode.sv
design/ladder_execute.sv
design/ladder_result.sv
design/ladder_top.sv
sim/tb_alu_model.sv
sim/tb_ladder.sv

/* Makefile */
# Verilator build of the ladder controller testbench

SRCS := $(shell grep -v '^+' compile.f) design/ladder_defs.svh

obj_dir/Vtb_ladder: compile.f $(SRCS)
	verilator --binary --timing --assert -f compile.f --top-module tb_ladder -o Vtb_ladder

.PHONY: run clean

# exit status of the simulator is the test verdict
run: obj_dir/Vtb_ladder
	./obj_dir/Vtb_ladder

clean:
	rm -rf obj_dir
